/* include/stereo_macros.svh */
`ifndef STEREO_MACROS_SVH
`define STEREO_MACROS_SVH

// ---------------------------------------------------------------------------
// Camera stream
// ---------------------------------------------------------------------------

`define STEREO_PIX_BITS     10
`define STEREO_LANES        4
`define STEREO_CAM_X_BITS   10
`define STEREO_CAM_Y_BITS   9

// ---------------------------------------------------------------------------
// Capture window and display raster
// ---------------------------------------------------------------------------

// Window size in pixels and lines
`define STEREO_WIN_X        32
`define STEREO_WIN_Y        16

`define STEREO_DISP_W       96
`define STEREO_DISP_H       24

`endif

/* rtl/cam_pkg.sv */
`include "stereo_macros.svh"

package cam_pkg;

    // Address split of one window buffer
    localparam int LANE_BITS     = $clog2(`STEREO_LANES);
    localparam int WIN_COL_BITS  = $clog2(`STEREO_WIN_X / `STEREO_LANES);
    localparam int WIN_LINE_BITS = $clog2(`STEREO_WIN_Y);

    typedef logic [`STEREO_PIX_BITS-1:0] pix_t;

    // Lane 0 in the low bits
    typedef pix_t [`STEREO_LANES-1:0] beat_t;

    typedef logic [`STEREO_CAM_X_BITS-1:0] cam_x_t;
    typedef logic [`STEREO_CAM_Y_BITS-1:0] cam_y_t;

    typedef logic [WIN_LINE_BITS+WIN_COL_BITS-1:0] win_addr_t;

endpackage

/* rtl/disp_pkg.sv */
`include "stereo_macros.svh"

package disp_pkg;

    // Raster position on the side-by-side display
    typedef logic [$clog2(`STEREO_DISP_W)-1:0] disp_x_t;
    typedef logic [$clog2(`STEREO_DISP_H)-1:0] disp_y_t;

endpackage

/* rtl/cam_beat_tracker.sv */
`timescale 1ns/1ns
`include "stereo_macros.svh"

module cam_beat_tracker (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               valid_i,
    input  logic               first_i,
    input  logic               last_i,
    input  cam_pkg::beat_t     data_i,
    output logic               wr_en_o,
    output cam_pkg::win_addr_t wr_addr_o,
    output cam_pkg::beat_t     wr_data_o
);

    // Position expected for the next beat
    cam_pkg::cam_x_t next_x;
    cam_pkg::cam_y_t next_y;

    // Position of the beat on the inputs
    cam_pkg::cam_x_t beat_x;
    cam_pkg::cam_y_t beat_y;
    logic            in_window;

    always_comb begin
        if (first_i) begin
            beat_x = '0;
            beat_y = '0;
        end else begin
            beat_x = next_x;
            beat_y = next_y;
        end
    end

    assign in_window = (beat_x < cam_pkg::cam_x_t'(`STEREO_WIN_X / `STEREO_LANES))
                    && (beat_y < cam_pkg::cam_y_t'(`STEREO_WIN_Y));

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            next_x <= '0;
            next_y <= '0;
        end else if (valid_i) begin
            if (last_i) begin
                next_x <= '0;
                next_y <= beat_y + 1'b1;
            end else begin
                next_x <= beat_x + 1'b1;
                next_y <= beat_y;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Write request towards the window buffer
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= valid_i && in_window;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            wr_addr_o <= {beat_y[cam_pkg::WIN_LINE_BITS-1:0],
                          beat_x[cam_pkg::WIN_COL_BITS-1:0]};
            wr_data_o <= data_i;
        end
    end

    // A line longer than the column counter would alias onto column 0
    a_no_col_wrap: assert property (
        @(posedge clk_i) disable iff (rst_i)
        valid_i && !last_i |-> beat_x != '1
    ) else $error("cam_beat_tracker: beat column counter wraps");

endmodule

/* rtl/window_ram.sv */
`timescale 1ns/1ns

module window_ram (
    input  logic               clk_i,
    input  logic               wr_en_i,
    input  cam_pkg::win_addr_t wr_addr_i,
    input  cam_pkg::beat_t     wr_data_i,
    input  cam_pkg::win_addr_t rd_addr_i,
    output cam_pkg::beat_t     rd_data_o
);

    localparam int DEPTH = 2 ** $bits(cam_pkg::win_addr_t);

    cam_pkg::beat_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Registered read, old data on a same-edge collision
    always_ff @(posedge clk_i) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* rtl/side_by_side_reader.sv */
`timescale 1ns/1ns
`include "stereo_macros.svh"

module side_by_side_reader (
    input  logic               clk_i,
    input  logic               rst_i,
    output cam_pkg::win_addr_t rd0_addr_o,
    output cam_pkg::win_addr_t rd1_addr_o,
    input  cam_pkg::beat_t     rd0_data_i,
    input  cam_pkg::beat_t     rd1_data_i,
    output logic               pix_valid_o,
    output logic               pix_first_o,
    output logic               pix_last_o,
    output cam_pkg::pix_t      pix_data_o
);

    // Each window centred in its half of the display
    localparam disp_pkg::disp_x_t ORG0_X =
        disp_pkg::disp_x_t'((`STEREO_DISP_W / 2 - `STEREO_WIN_X) / 2);
    localparam disp_pkg::disp_x_t ORG1_X =
        disp_pkg::disp_x_t'((`STEREO_DISP_W / 2 - `STEREO_WIN_X) / 2 + `STEREO_DISP_W / 2);
    localparam disp_pkg::disp_y_t ORG_Y =
        disp_pkg::disp_y_t'((`STEREO_DISP_H - `STEREO_WIN_Y) / 2);

    localparam disp_pkg::disp_x_t LAST_X = disp_pkg::disp_x_t'(`STEREO_DISP_W - 1);
    localparam disp_pkg::disp_y_t LAST_Y = disp_pkg::disp_y_t'(`STEREO_DISP_H - 1);

    disp_pkg::disp_x_t ras_x;
    disp_pkg::disp_y_t ras_y;

    // Raster position relative to each window origin
    disp_pkg::disp_x_t rel0_x;
    disp_pkg::disp_x_t rel1_x;
    disp_pkg::disp_y_t rel_y;
    logic              hit0;
    logic              hit1;

    logic                            s1_valid;
    logic                            s1_first;
    logic                            s1_last;
    logic                            s1_hit0;
    logic                            s1_hit1;
    logic [cam_pkg::LANE_BITS-1:0]   s1_lane;

    logic                            s2_valid;
    logic                            s2_first;
    logic                            s2_last;
    logic                            s2_hit0;
    logic                            s2_hit1;
    logic [cam_pkg::LANE_BITS-1:0]   s2_lane;

    // ------------------------------------------------------------------------
    // Raster scan, no blanking
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ras_x <= '0;
            ras_y <= '0;
        end else if (ras_x == LAST_X) begin
            ras_x <= '0;
            ras_y <= (ras_y == LAST_Y) ? '0 : ras_y + 1'b1;
        end else begin
            ras_x <= ras_x + 1'b1;
        end
    end

    // Left of an origin wraps to a large value and misses the window
    assign rel0_x = ras_x - ORG0_X;
    assign rel1_x = ras_x - ORG1_X;
    assign rel_y  = ras_y - ORG_Y;

    assign hit0 = (rel0_x < disp_pkg::disp_x_t'(`STEREO_WIN_X))
               && (rel_y < disp_pkg::disp_y_t'(`STEREO_WIN_Y));
    assign hit1 = (rel1_x < disp_pkg::disp_x_t'(`STEREO_WIN_X))
               && (rel_y < disp_pkg::disp_y_t'(`STEREO_WIN_Y));

    // ------------------------------------------------------------------------
    // Stage 1, buffer addresses
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
            s1_last  <= 1'b0;
            s1_hit0  <= 1'b0;
            s1_hit1  <= 1'b0;
        end else begin
            s1_valid <= 1'b1;
            s1_first <= (ras_x == '0) && (ras_y == '0);
            s1_last  <= (ras_x == LAST_X);
            s1_hit0  <= hit0;
            s1_hit1  <= hit1;
        end
    end

    always_ff @(posedge clk_i) begin
        rd0_addr_o <= {rel_y[cam_pkg::WIN_LINE_BITS-1:0],
                       rel0_x[cam_pkg::LANE_BITS +: cam_pkg::WIN_COL_BITS]};
        rd1_addr_o <= {rel_y[cam_pkg::WIN_LINE_BITS-1:0],
                       rel1_x[cam_pkg::LANE_BITS +: cam_pkg::WIN_COL_BITS]};
        s1_lane    <= hit1 ? rel1_x[cam_pkg::LANE_BITS-1:0]
                           : rel0_x[cam_pkg::LANE_BITS-1:0];
    end

    // Stage 2, RAM read in flight
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            s2_valid <= 1'b0;
            s2_first <= 1'b0;
            s2_last  <= 1'b0;
            s2_hit0  <= 1'b0;
            s2_hit1  <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
            s2_first <= s1_first;
            s2_last  <= s1_last;
            s2_hit0  <= s1_hit0;
            s2_hit1  <= s1_hit1;
        end
    end

    always_ff @(posedge clk_i) begin
        s2_lane <= s1_lane;
    end

    // ------------------------------------------------------------------------
    // Stage 3, lane select and output
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pix_valid_o <= 1'b0;
            pix_first_o <= 1'b0;
            pix_last_o  <= 1'b0;
        end else begin
            pix_valid_o <= s2_valid;
            pix_first_o <= s2_first;
            pix_last_o  <= s2_last;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s2_hit0) begin
            pix_data_o <= rd0_data_i[s2_lane];
        end else if (s2_hit1) begin
            pix_data_o <= rd1_data_i[s2_lane];
        end else begin
            pix_data_o <= '0;
        end
    end

    // Origins must keep the two windows apart
    a_one_window: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(s2_hit0 && s2_hit1)
    ) else $error("side_by_side_reader: both windows hit at once");

endmodule

/* rtl/stereo_window_top.sv */
`timescale 1ns/1ns

module stereo_window_top (
    input  logic           axi4s_cam0_rx,
    input  logic           sys_reset,
    input  logic           cam0_valid_i,
    input  logic           cam0_first_i,
    input  logic           cam0_last_i,
    input  cam_pkg::beat_t cam0_data_i,
    input  logic           cam1_valid_i,
    input  logic           cam1_first_i,
    input  logic           cam1_last_i,
    input  cam_pkg::beat_t cam1_data_i,
    output logic           pix_valid_o,
    output logic           pix_first_o,
    output logic           pix_last_o,
    output cam_pkg::pix_t  pix_data_o
);

    logic               wr0_en;
    cam_pkg::win_addr_t wr0_addr;
    cam_pkg::beat_t     wr0_data;
    logic               wr1_en;
    cam_pkg::win_addr_t wr1_addr;
    cam_pkg::beat_t     wr1_data;

    cam_pkg::win_addr_t rd0_addr;
    cam_pkg::beat_t     rd0_data;
    cam_pkg::win_addr_t rd1_addr;
    cam_pkg::beat_t     rd1_data;

    // ------------------------------------------------------------------------
    // Capture side
    // ------------------------------------------------------------------------

    cam_beat_tracker u_track_cam0 (
        .clk_i     (axi4s_cam0_rx),
        .rst_i     (sys_reset),
        .valid_i   (cam0_valid_i),
        .first_i   (cam0_first_i),
        .last_i    (cam0_last_i),
        .data_i    (cam0_data_i),
        .wr_en_o   (wr0_en),
        .wr_addr_o (wr0_addr),
        .wr_data_o (wr0_data)
    );

    cam_beat_tracker u_track_cam1 (
        .clk_i     (axi4s_cam0_rx),
        .rst_i     (sys_reset),
        .valid_i   (cam1_valid_i),
        .first_i   (cam1_first_i),
        .last_i    (cam1_last_i),
        .data_i    (cam1_data_i),
        .wr_en_o   (wr1_en),
        .wr_addr_o (wr1_addr),
        .wr_data_o (wr1_data)
    );

    window_ram u_ram_cam0 (
        .clk_i     (axi4s_cam0_rx),
        .wr_en_i   (wr0_en),
        .wr_addr_i (wr0_addr),
        .wr_data_i (wr0_data),
        .rd_addr_i (rd0_addr),
        .rd_data_o (rd0_data)
    );

    window_ram u_ram_cam1 (
        .clk_i     (axi4s_cam0_rx),
        .wr_en_i   (wr1_en),
        .wr_addr_i (wr1_addr),
        .wr_data_i (wr1_data),
        .rd_addr_i (rd1_addr),
        .rd_data_o (rd1_data)
    );

    // Display side
    side_by_side_reader u_reader (
        .clk_i       (axi4s_cam0_rx),
        .rst_i       (sys_reset),
        .rd0_addr_o  (rd0_addr),
        .rd1_addr_o  (rd1_addr),
        .rd0_data_i  (rd0_data),
        .rd1_data_i  (rd1_data),
        .pix_valid_o (pix_valid_o),
        .pix_first_o (pix_first_o),
        .pix_last_o  (pix_last_o),
        .pix_data_o  (pix_data_o)
    );

endmodule

/* tb/tb_stereo_window.sv */
`timescale 1ns/1ns
`include "stereo_macros.svh"

module tb_stereo_window;

    localparam int WIN_BEATS     = `STEREO_WIN_X / `STEREO_LANES;
    localparam int WIN_WORDS     = WIN_BEATS * `STEREO_WIN_Y;
    localparam int FRAME_PIX     = `STEREO_DISP_W * `STEREO_DISP_H;
    // Window centre on the centre of each display half
    localparam int ORG0_X        = `STEREO_DISP_W / 4 - `STEREO_WIN_X / 2;
    localparam int ORG1_X        = ORG0_X + `STEREO_DISP_W / 2;
    localparam int ORG_Y         = `STEREO_DISP_H / 2 - `STEREO_WIN_Y / 2;
    localparam int FIRST_TIMEOUT = 2 * FRAME_PIX;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic           axi4s_cam0_rx;
    logic           sys_reset;
    logic           cam0_valid;
    logic           cam0_first;
    logic           cam0_last;
    cam_pkg::beat_t cam0_data;
    logic           cam1_valid;
    logic           cam1_first;
    logic           cam1_last;
    cam_pkg::beat_t cam1_data;
    logic           pix_valid;
    logic           pix_first;
    logic           pix_last;
    cam_pkg::pix_t  pix_data;

    // Window contents as the camera rules predict them
    cam_pkg::beat_t model_buf [2][WIN_WORDS];
    int             next_x [2];
    int             next_y [2];

    logic [31:0] lfsr;
    int          value_errors;
    int          other_errors;
    int          pixels_checked;
    bit          check_on;
    bit          aborted;

    // Display position seen by the compare process
    bit frame_seen;
    bit valid_seen;
    int px;
    int py;
    int pix_count;

    stereo_window_top dut_i (
        .axi4s_cam0_rx (axi4s_cam0_rx),
        .sys_reset     (sys_reset),
        .cam0_valid_i  (cam0_valid),
        .cam0_first_i  (cam0_first),
        .cam0_last_i   (cam0_last),
        .cam0_data_i   (cam0_data),
        .cam1_valid_i  (cam1_valid),
        .cam1_first_i  (cam1_first),
        .cam1_last_i   (cam1_last),
        .cam1_data_i   (cam1_data),
        .pix_valid_o   (pix_valid),
        .pix_first_o   (pix_first),
        .pix_last_o    (pix_last),
        .pix_data_o    (pix_data)
    );

    always #5 axi4s_cam0_rx = ~axi4s_cam0_rx;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    function automatic logic [39:0] random_bits(input int n);
        logic [39:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[38:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
        end
        return r;
    endfunction

    function automatic cam_pkg::pix_t expected_pix(input int x, input int y);
        int             wx;
        int             wy;
        cam_pkg::beat_t word;
        wy = y - ORG_Y;
        if (wy < 0 || wy >= `STEREO_WIN_Y) begin
            return '0;
        end
        wx = x - ORG0_X;
        if (wx >= 0 && wx < `STEREO_WIN_X) begin
            word = model_buf[0][wy * WIN_BEATS + wx / `STEREO_LANES];
            return word[wx % `STEREO_LANES];
        end
        wx = x - ORG1_X;
        if (wx >= 0 && wx < `STEREO_WIN_X) begin
            word = model_buf[1][wy * WIN_BEATS + wx / `STEREO_LANES];
            return word[wx % `STEREO_LANES];
        end
        return '0;
    endfunction

    task automatic check_value(input string name, input logic [39:0] got,
                               input logic [39:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("error %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic step();
        @(posedge axi4s_cam0_rx);
        #1;
    endtask

    // Drives one camera and applies the beat position rules to the model
    task automatic set_cam(input int cam, input bit valid, input bit first,
                           input bit last, input cam_pkg::beat_t data);
        int bx;
        int by;
        if (valid) begin
            bx = first ? 0 : next_x[cam];
            by = first ? 0 : next_y[cam];
            if (bx < WIN_BEATS && by < `STEREO_WIN_Y) begin
                model_buf[cam][by * WIN_BEATS + bx] = data;
            end
            next_x[cam] = last ? 0 : bx + 1;
            next_y[cam] = last ? by + 1 : by;
        end
        if (cam == 0) begin
            cam0_valid = valid;
            cam0_first = first;
            cam0_last  = last;
            cam0_data  = data;
        end else begin
            cam1_valid = valid;
            cam1_first = first;
            cam1_last  = last;
            cam1_data  = data;
        end
    endtask

    task automatic idle_cams();
        set_cam(0, 1'b0, 1'b0, 1'b0, '0);
        set_cam(1, 1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic send_frame(input bit use0, input bit use1, input int cols,
                              input int lines, input bit gaps);
        for (int l = 0; l < lines; l++) begin
            for (int c = 0; c < cols; c++) begin
                if (gaps && random_bits(1) == 1) begin
                    idle_cams();
                    step();
                end
                idle_cams();
                if (use0) begin
                    set_cam(0, 1'b1, l == 0 && c == 0, c == cols - 1, random_bits(40));
                end
                if (use1) begin
                    set_cam(1, 1'b1, l == 0 && c == 0, c == cols - 1, random_bits(40));
                end
                step();
            end
        end
        idle_cams();
    endtask

    // A line that is left without its last beat
    task automatic send_partial_line(input int cam, input int beats);
        for (int i = 0; i < beats; i++) begin
            set_cam(cam, 1'b1, 1'b0, 1'b0, random_bits(40));
            step();
        end
        idle_cams();
    endtask

    task automatic wait_first();
        int n;
        n = 0;
        do begin
            step();
            n++;
        end while (!(pix_valid === 1'b1 && pix_first === 1'b1) && n < FIRST_TIMEOUT);
        if (!(pix_valid === 1'b1 && pix_first === 1'b1)) begin
            other_errors++;
            aborted = 1'b1;
            $display("timeout: no pix_first_o within %0d cycles", FIRST_TIMEOUT);
        end
    endtask

    // Compares the next complete display frame against the model
    task automatic check_frame();
        repeat (4) step();
        wait_first();
        if (aborted) begin
            return;
        end
        check_on = 1'b1;
        wait_first();
        check_on = 1'b0;
    endtask

    task automatic run_sequence();
        send_frame(1'b1, 1'b1, WIN_BEATS, `STEREO_WIN_Y, 1'b0);
        check_frame();
        if (aborted) begin
            return;
        end
        // Oversized frame whose window part alone lands in the buffers
        send_frame(1'b1, 1'b1, WIN_BEATS + 4, `STEREO_WIN_Y + 4, 1'b1);
        check_frame();
        if (aborted) begin
            return;
        end
        send_partial_line(1, 5);
        repeat (3) step();
        send_frame(1'b0, 1'b1, WIN_BEATS, `STEREO_WIN_Y, 1'b1);
        check_frame();
    endtask

    // ------------------------------------------------------------------------
    // Compare process
    // ------------------------------------------------------------------------

    always @(negedge axi4s_cam0_rx) begin
        if (pix_valid === 1'b1) begin
            valid_seen = 1'b1;
            if (pix_first === 1'b1) begin
                if (frame_seen) begin
                    check_value("pix_first_o period", pix_count, FRAME_PIX);
                end
                frame_seen = 1'b1;
                px = 0;
                py = 0;
                pix_count = 1;
            end else if (frame_seen) begin
                px++;
                if (px == `STEREO_DISP_W) begin
                    px = 0;
                    py++;
                end
                pix_count++;
            end
            if (frame_seen) begin
                check_value("pix_last_o", pix_last, px == `STEREO_DISP_W - 1);
            end
            if (check_on) begin
                check_value("pix_data_o", pix_data, expected_pix(px, py));
                pixels_checked++;
            end
        end else if (valid_seen) begin
            other_errors++;
            $display("pix_valid_o dropped after the display started at %0t", $time);
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin
        axi4s_cam0_rx  = 1'b0;
        sys_reset      = 1'b1;
        lfsr           = 32'd99877;
        value_errors   = 0;
        other_errors   = 0;
        pixels_checked = 0;
        check_on       = 1'b0;
        aborted        = 1'b0;
        frame_seen     = 1'b0;
        valid_seen     = 1'b0;
        px             = 0;
        py             = 0;
        pix_count      = 0;
        next_x         = '{0, 0};
        next_y         = '{0, 0};
        idle_cams();

        repeat (16) @(posedge axi4s_cam0_rx);
        #1;
        check_value("pix_valid_o", pix_valid, 1'b0);
        sys_reset = 1'b0;
        step();
        check_value("pix_valid_o", pix_valid, 1'b0);
        step();
        check_value("pix_valid_o", pix_valid, 1'b0);
        step();
        check_value("pix_valid_o", pix_valid, 1'b1);
        check_value("pix_first_o", pix_first, 1'b1);

        run_sequence();

        if (!aborted && pixels_checked != 3 * FRAME_PIX) begin
            other_errors++;
            $display("only %0d of %0d display pixels were compared",
                     pixels_checked, 3 * FRAME_PIX);
        end
        $display("%0d value errors, %0d other errors, %0d pixels compared",
                 value_errors, other_errors, pixels_checked);
        if (value_errors == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+include
rtl/cam_pkg.sv
rtl/disp_pkg.sv
rtl/cam_beat_tracker.sv
rtl/window_ram.sv
rtl/side_by_side_reader.sv
rtl/stereo_window_top.sv
tb/tb_stereo_window.sv

/* Bender.yml */
package:
  name: stereo_window

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/cam_pkg.sv
      - rtl/disp_pkg.sv
      - rtl/cam_beat_tracker.sv
      - rtl/window_ram.sv
      - rtl/side_by_side_reader.sv
      - rtl/stereo_window_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_stereo_window.sv
